/* hw/decode_pkg.sv */
package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [alu_op_w-1:0]   alu_op_t;

    // bit positions inside the one-hot alu_op
    localparam int alu_add  = 0;  // addu, addiu, lw, sw, jal, jalr
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // SPECIAL function field
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_jump_imm,  // j, jal
        br_jump_reg   // jr, jalr
    } br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_8;   // link address is pc + 8
        logic      mem_re;
        logic      mem_we;
        logic      gpr_we;
        reg_addr_t dest;
        br_kind_t  br_kind;
        logic      uses_rs;
        logic      uses_rt;
        logic      exc_ri;
    } ctrl_t;

endpackage

/* hw/bypass_if.sv */
`timescale 1ns/1ps

interface bypass_if;
    import decode_pkg::*;

    logic      es_res_valid;  // low while a load is still in execute
    reg_addr_t es_dest;
    word_t     es_res;
    logic      ms_res_valid;
    reg_addr_t ms_dest;
    word_t     ms_res;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    modport src(
        output es_res_valid, es_dest, es_res,
        output ms_res_valid, ms_dest, ms_res,
        output wb_we, wb_addr, wb_data
    );

    modport sink(
        input es_res_valid, es_dest, es_res,
        input ms_res_valid, ms_dest, ms_res,
        input wb_we, wb_addr, wb_data
    );

    modport br(input es_res_valid, es_dest);

endinterface

/* hw/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::word_t     inst,
    output decode_pkg::ctrl_t     ctrl,
    output decode_pkg::reg_addr_t rs,
    output decode_pkg::reg_addr_t rt,
    output logic [4:0]            sa,
    output logic [15:0]           imm,
    output logic [25:0]           jidx
);
    import decode_pkg::*;

    logic [5:0] op;
    logic [5:0] func;
    reg_addr_t  rd;
    logic       spec;      // SPECIAL with sa == 0
    logic       i_addu, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
    logic       i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav;
    logic       i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic       i_lw, i_sw;
    logic       i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz;
    logic       i_j, i_jal, i_jr, i_jalr;
    logic       shift_sa;  // shift amount taken from the sa field
    logic       reg_alu;
    logic       imm_alu;
    logic       branch;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign imm  = inst[15:0];
    assign jidx = inst[25:0];

    assign spec = (op == op_special) && (sa == 5'd0);

    assign i_addu = spec && (func == fn_addu);
    assign i_subu = spec && (func == fn_subu);
    assign i_slt  = spec && (func == fn_slt);
    assign i_sltu = spec && (func == fn_sltu);
    assign i_and  = spec && (func == fn_and);
    assign i_or   = spec && (func == fn_or);
    assign i_xor  = spec && (func == fn_xor);
    assign i_nor  = spec && (func == fn_nor);
    assign i_sllv = spec && (func == fn_sllv);
    assign i_srlv = spec && (func == fn_srlv);
    assign i_srav = spec && (func == fn_srav);
    // constant shifts need rs == 0 instead
    assign i_sll  = (op == op_special) && (rs == 5'd0) && (func == fn_sll);
    assign i_srl  = (op == op_special) && (rs == 5'd0) && (func == fn_srl);
    assign i_sra  = (op == op_special) && (rs == 5'd0) && (func == fn_sra);
    assign i_jr   = spec && (func == fn_jr) && (rt == 5'd0) && (rd == 5'd0);
    assign i_jalr = spec && (func == fn_jalr) && (rt == 5'd0);

    assign i_addiu = (op == op_addiu);
    assign i_slti  = (op == op_slti);
    assign i_sltiu = (op == op_sltiu);
    assign i_andi  = (op == op_andi);
    assign i_ori   = (op == op_ori);
    assign i_xori  = (op == op_xori);
    assign i_lui   = (op == op_lui) && (rs == 5'd0);
    assign i_lw    = (op == op_lw);
    assign i_sw    = (op == op_sw);
    assign i_beq   = (op == op_beq);
    assign i_bne   = (op == op_bne);
    assign i_bgez  = (op == op_regimm) && (rt == 5'h01);
    assign i_bltz  = (op == op_regimm) && (rt == 5'h00);
    assign i_bgtz  = (op == op_bgtz) && (rt == 5'd0);
    assign i_blez  = (op == op_blez) && (rt == 5'd0);
    assign i_j     = (op == op_j);
    assign i_jal   = (op == op_jal);

    assign shift_sa = i_sll | i_srl | i_sra;
    assign reg_alu  = |{i_addu, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor,
                        shift_sa, i_sllv, i_srlv, i_srav};
    assign imm_alu  = |{i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui};
    assign branch   = |{i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz};

    always_comb begin
        ctrl.alu_op           = '0;
        ctrl.alu_op[alu_add]  = i_addu | i_addiu | i_lw | i_sw | i_jal | i_jalr;
        ctrl.alu_op[alu_sub]  = i_subu;
        ctrl.alu_op[alu_slt]  = i_slt | i_slti;
        ctrl.alu_op[alu_sltu] = i_sltu | i_sltiu;
        ctrl.alu_op[alu_and]  = i_and | i_andi;
        ctrl.alu_op[alu_nor]  = i_nor;
        ctrl.alu_op[alu_or]   = i_or | i_ori;
        ctrl.alu_op[alu_xor]  = i_xor | i_xori;
        ctrl.alu_op[alu_sll]  = i_sll | i_sllv;
        ctrl.alu_op[alu_srl]  = i_srl | i_srlv;
        ctrl.alu_op[alu_sra]  = i_sra | i_srav;
        ctrl.alu_op[alu_lui]  = i_lui;

        ctrl.src1_is_sa  = shift_sa;
        ctrl.src1_is_pc  = i_jal | i_jalr;
        ctrl.src2_is_imm = imm_alu | i_lw | i_sw;  // andi/ori/xori zero-extend in ex
        ctrl.src2_is_8   = i_jal | i_jalr;
        ctrl.mem_re      = i_lw;
        ctrl.mem_we      = i_sw;
        ctrl.gpr_we      = ~(i_sw | branch | i_j | i_jr);

        if (i_jal)
            ctrl.dest = 5'd31;
        else if (imm_alu || i_lw)
            ctrl.dest = rt;
        else
            ctrl.dest = rd;

        if (i_beq)                ctrl.br_kind = br_beq;
        else if (i_bne)           ctrl.br_kind = br_bne;
        else if (i_bgez)          ctrl.br_kind = br_bgez;
        else if (i_bgtz)          ctrl.br_kind = br_bgtz;
        else if (i_blez)          ctrl.br_kind = br_blez;
        else if (i_bltz)          ctrl.br_kind = br_bltz;
        else if (i_j || i_jal)    ctrl.br_kind = br_jump_imm;
        else if (i_jr || i_jalr)  ctrl.br_kind = br_jump_reg;
        else                      ctrl.br_kind = br_none;

        ctrl.uses_rs = (reg_alu & ~shift_sa) | (imm_alu & ~i_lui) | i_lw | i_sw
                     | branch | i_jr | i_jalr;
        ctrl.uses_rt = reg_alu | i_sw | i_beq | i_bne;
        ctrl.exc_ri  = ~|{reg_alu, imm_alu, i_lw, i_sw, branch, i_j, i_jal, i_jr, i_jalr};
    end

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  logic                  we,
    input  decode_pkg::reg_addr_t waddr,
    input  decode_pkg::word_t     wdata,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);
    import decode_pkg::*;

    word_t regs [1:(1 << reg_addr_w) - 1];  // no storage for $0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(waddr));

endmodule

/* hw/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  decode_pkg::word_t     rf_rs,
    input  decode_pkg::word_t     rf_rt,
    bypass_if.sink                bp,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output logic                  ready_go
);
    import decode_pkg::*;

    logic rs_es, rs_ms, rs_wb;
    logic rt_es, rt_ms, rt_wb;
    logic es_block;
    logic ms_block;

    // nonzero index equal to a producer dest
    function automatic logic hit(input reg_addr_t src, input reg_addr_t dst);
        return (src != '0) && (src == dst);
    endfunction

    assign rs_es = hit(rs, bp.es_dest);
    assign rs_ms = hit(rs, bp.ms_dest);
    assign rs_wb = bp.wb_we && hit(rs, bp.wb_addr);
    assign rt_es = hit(rt, bp.es_dest);
    assign rt_ms = hit(rt, bp.ms_dest);
    assign rt_wb = bp.wb_we && hit(rt, bp.wb_addr);

    // youngest producer first
    always_comb begin
        if (rs_es)
            rs_value = bp.es_res;
        else if (rs_ms)
            rs_value = bp.ms_res;
        else if (rs_wb)
            rs_value = bp.wb_data;  // same-cycle write not yet in the file
        else
            rs_value = rf_rs;

        if (rt_es)
            rt_value = bp.es_res;
        else if (rt_ms)
            rt_value = bp.ms_res;
        else if (rt_wb)
            rt_value = bp.wb_data;
        else
            rt_value = rf_rt;
    end

    // producer result not ready yet, e.g. a load in flight
    assign es_block = !bp.es_res_valid && (uses_rs && rs_es || uses_rt && rt_es);
    assign ms_block = !bp.ms_res_valid && (uses_rs && rs_ms || uses_rt && rt_ms);
    assign ready_go = !(es_block || ms_block);

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic                  ds_valid,
    input  decode_pkg::br_kind_t  br_kind,
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  decode_pkg::word_t     rs_value,
    input  decode_pkg::word_t     rt_value,
    input  logic [15:0]           imm,
    input  logic [25:0]           jidx,
    input  decode_pkg::word_t     fs_pc,   // pc of the delay slot
    bypass_if.br                  bp,
    output logic                  br_stall,
    output logic                  br_taken,
    output decode_pkg::word_t     br_target
);
    import decode_pkg::*;

    logic  cond;
    logic  is_cmp;      // beq / bne read rt too
    logic  is_branch;
    logic  rs_zero;
    word_t br_offset;

    assign rs_zero   = (rs_value == '0);
    assign is_cmp    = (br_kind == br_beq) || (br_kind == br_bne);
    assign is_branch = is_cmp || (br_kind inside {br_bgez, br_bgtz, br_blez, br_bltz});
    assign br_offset = {{(xlen - 18){imm[15]}}, imm, 2'b00};

    always_comb begin
        case (br_kind)
            br_beq:      cond = (rs_value == rt_value);
            br_bne:      cond = (rs_value != rt_value);
            br_bgez:     cond = !rs_value[xlen-1];
            br_bgtz:     cond = !rs_value[xlen-1] && !rs_zero;
            br_blez:     cond = rs_value[xlen-1] || rs_zero;
            br_bltz:     cond = rs_value[xlen-1];
            br_jump_imm: cond = 1'b1;
            br_jump_reg: cond = 1'b1;
            default:     cond = 1'b0;
        endcase
    end

    assign br_taken = ds_valid && cond;

    always_comb begin
        if (is_branch)
            br_target = fs_pc + br_offset;
        else if (br_kind == br_jump_imm)
            br_target = {fs_pc[xlen-1:28], jidx, 2'b00};
        else if (br_kind == br_jump_reg)
            br_target = rs_value;
        else
            br_target = '0;
    end

    // compare operand still being computed in execute
    assign br_stall = ds_valid && !bp.es_res_valid && (bp.es_dest != '0)
                    && ((is_branch || br_kind == br_jump_reg) && (rs == bp.es_dest)
                        || is_cmp && (rt == bp.es_dest));

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  fs_valid,
    input  decode_pkg::word_t     fs_inst,
    input  decode_pkg::word_t     fs_pc,
    input  logic                  es_allowin,
    input  logic                  es_res_valid,
    input  decode_pkg::reg_addr_t es_dest,
    input  decode_pkg::word_t     es_res,
    input  logic                  ms_res_valid,
    input  decode_pkg::reg_addr_t ms_dest,
    input  decode_pkg::word_t     ms_res,
    input  logic                  wb_we,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::word_t     ds_pc,
    output decode_pkg::alu_op_t   alu_op,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  src2_is_8,
    output logic                  mem_re,
    output logic                  mem_we,
    output logic                  gpr_we,
    output decode_pkg::reg_addr_t dest,
    output logic [15:0]           imm,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output logic                  exc_ri,
    output logic                  br_valid,
    output logic                  br_stall,
    output logic                  br_taken,
    output decode_pkg::word_t     br_target
);
    import decode_pkg::*;

    logic        ds_valid;
    logic        ds_ready_go;
    word_t       ds_inst;
    ctrl_t       ctrl;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [25:0] jidx;
    word_t       rf_rs;
    word_t       rf_rt;

    bypass_if bp0();

    assign bp0.es_res_valid = es_res_valid;
    assign bp0.es_dest      = es_dest;
    assign bp0.es_res       = es_res;
    assign bp0.ms_res_valid = ms_res_valid;
    assign bp0.ms_dest      = ms_dest;
    assign bp0.ms_res       = ms_res;
    assign bp0.wb_we        = wb_we;
    assign bp0.wb_addr      = wb_addr;
    assign bp0.wb_data      = wb_data;

    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;
    assign br_valid       = ds_to_es_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ds_valid <= 1'b0;
        else if (flush)
            ds_valid <= 1'b0;
        else if (ds_allowin)
            ds_valid <= fs_valid;
    end

    // instruction and pc held while execute stalls
    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder dec0 (
        .inst (ds_inst),
        .ctrl (ctrl),
        .rs   (rs),
        .rt   (rt),
        .sa   (),
        .imm  (imm),
        .jidx (jidx)
    );

    regfile rf0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs),
        .raddr2 (rt),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    operand_bypass byp0 (
        .rs       (rs),
        .rt       (rt),
        .uses_rs  (ctrl.uses_rs),
        .uses_rt  (ctrl.uses_rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .bp       (bp0.sink),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready_go (ds_ready_go)
    );

    branch_unit bru0 (
        .ds_valid  (ds_valid),
        .br_kind   (ctrl.br_kind),
        .rs        (rs),
        .rt        (rt),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .imm       (imm),
        .jidx      (jidx),
        .fs_pc     (fs_pc),
        .bp        (bp0.br),
        .br_stall  (br_stall),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    assign alu_op      = ctrl.alu_op;
    assign src1_is_sa  = ctrl.src1_is_sa;
    assign src1_is_pc  = ctrl.src1_is_pc;
    assign src2_is_imm = ctrl.src2_is_imm;
    assign src2_is_8   = ctrl.src2_is_8;
    assign mem_re      = ctrl.mem_re;
    assign mem_we      = ctrl.mem_we;
    assign gpr_we      = ctrl.gpr_we;
    assign dest        = ctrl.dest;
    assign exc_ri      = ctrl.exc_ri;

    // an offered instruction stays put while execute refuses it
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ds_to_es_valid && !es_allowin && !flush
        |=> ds_valid && $stable(ds_pc) && $stable(ds_inst));

    // the bus to execute is fully defined once an instruction is held
    a_out_known: assert property (@(posedge clk) disable iff (!rst_n)
        ds_valid |-> !$isunknown({ds_pc, ctrl, imm, rs_value, rt_value,
                                  ds_to_es_valid, br_stall, br_taken, br_target}));

endmodule

/* tests/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    logic      clk, rst_n, flush, fs_valid, es_allowin;
    logic      es_res_valid, ms_res_valid, wb_we;
    word_t     fs_inst, fs_pc, es_res, ms_res, wb_data;
    reg_addr_t es_dest, ms_dest, wb_addr;

    logic        ds_allowin, ds_to_es_valid, exc_ri, br_valid, br_stall, br_taken;
    logic        src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8, mem_re, mem_we, gpr_we;
    word_t       ds_pc, rs_value, rt_value, br_target;
    alu_op_t     alu_op;
    reg_addr_t   dest;
    logic [15:0] imm;

    integer seed;
    int     err_count;
    int     cycle_count;

    decode_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // tests need roughly 250 cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 2000) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic word_t r_inst(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_inst(input logic [5:0] op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] value);
        return {op, rs, rt, value};
    endfunction

    function automatic word_t j_inst(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // put an instruction on the fetch side, wait until decode can take it
    task automatic offer_inst(input word_t inst, input word_t pc);
        @(posedge clk);
        fs_valid <= 1'b1;
        fs_inst  <= inst;
        fs_pc    <= pc;
        @(negedge clk);
        while (!ds_allowin) @(negedge clk);
    endtask

    // capture edge, delay slot pc follows behind
    task automatic take_inst(input word_t next_pc);
        @(posedge clk);
        fs_valid <= 1'b0;
        fs_pc    <= next_pc;
    endtask

    task automatic run_inst(input word_t inst, input word_t pc);
        offer_inst(inst, pc);
        take_inst(pc + 32'd4);
        @(negedge clk);
    endtask

    task automatic wait_issue();
        @(negedge clk);
        while (!ds_to_es_valid) @(negedge clk);
    endtask

    task automatic write_reg(input reg_addr_t r, input word_t v);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_addr <= r;
        wb_data <= v;
        @(posedge clk);
        wb_we   <= 1'b0;
    endtask

    // flags are {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8, mem_re, mem_we, gpr_we}
    task automatic decode_case(input word_t inst, input int alu_bit,
                               input logic [6:0] flags, input reg_addr_t exp_dest);
        alu_op_t exp_op;
        exp_op = '0;
        exp_op[alu_bit] = 1'b1;
        run_inst(inst, 32'h0000_0100);
        compare("ds_to_es_valid", ds_to_es_valid, 1);
        compare("alu_op", alu_op, exp_op);
        compare("flags", {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8,
                          mem_re, mem_we, gpr_we}, flags);
        compare("dest", dest, exp_dest);
        compare("imm", imm, inst[15:0]);
        compare("exc_ri", exc_ri, 0);
    endtask

    task automatic decode_fields();
        decode_case(r_inst(1, 2, 3, 0, fn_addu), alu_add, 7'b0000001, 3);
        decode_case(r_inst(1, 2, 3, 0, fn_subu), alu_sub, 7'b0000001, 3);
        decode_case(r_inst(1, 2, 3, 0, fn_slt), alu_slt, 7'b0000001, 3);
        decode_case(r_inst(1, 2, 3, 0, fn_sltu), alu_sltu, 7'b0000001, 3);
        decode_case(r_inst(1, 2, 3, 0, fn_and), alu_and, 7'b0000001, 3);
        decode_case(r_inst(1, 2, 3, 0, fn_or), alu_or, 7'b0000001, 3);
        decode_case(r_inst(1, 2, 3, 0, fn_xor), alu_xor, 7'b0000001, 3);
        decode_case(r_inst(1, 2, 3, 0, fn_nor), alu_nor, 7'b0000001, 3);
        decode_case(r_inst(0, 2, 4, 5, fn_sll), alu_sll, 7'b1000001, 4);
        decode_case(r_inst(0, 2, 4, 5, fn_srl), alu_srl, 7'b1000001, 4);
        decode_case(r_inst(0, 2, 4, 5, fn_sra), alu_sra, 7'b1000001, 4);
        decode_case(r_inst(1, 2, 4, 0, fn_sllv), alu_sll, 7'b0000001, 4);
        decode_case(r_inst(1, 2, 4, 0, fn_srlv), alu_srl, 7'b0000001, 4);
        decode_case(r_inst(1, 2, 4, 0, fn_srav), alu_sra, 7'b0000001, 4);
        decode_case(i_inst(op_addiu, 1, 5, 16'h1234), alu_add, 7'b0010001, 5);
        decode_case(i_inst(op_slti, 1, 5, 16'h8001), alu_slt, 7'b0010001, 5);
        decode_case(i_inst(op_sltiu, 1, 5, 16'h0007), alu_sltu, 7'b0010001, 5);
        decode_case(i_inst(op_andi, 1, 5, 16'h00ff), alu_and, 7'b0010001, 5);
        decode_case(i_inst(op_ori, 1, 5, 16'hf0f0), alu_or, 7'b0010001, 5);
        decode_case(i_inst(op_xori, 1, 5, 16'h5a5a), alu_xor, 7'b0010001, 5);
        decode_case(i_inst(op_lui, 0, 6, 16'hbeef), alu_lui, 7'b0010001, 6);
        decode_case(i_inst(op_lw, 1, 7, 16'h0040), alu_add, 7'b0010101, 7);
        decode_case(i_inst(op_sw, 1, 2, 16'h0008), alu_add, 7'b0010010, 0);  // rd field is 0
        decode_case(j_inst(op_jal, 26'h000_0010), alu_add, 7'b0101001, 31);
        run_inst(32'hfc00_0000, 32'h0000_0200);  // opcode 0x3f
        compare("exc_ri", exc_ri, 1);
        run_inst(r_inst(1, 2, 3, 1, fn_addu), 32'h0000_0200);  // sa must be zero
        compare("exc_ri", exc_ri, 1);
    endtask

    task automatic regfile_forward();
        word_t vals [1:4];
        word_t fwd;
        for (int r = 1; r <= 4; r++) begin
            vals[r] = $random(seed);
            write_reg(r, vals[r]);
        end
        write_reg(0, 32'hffff_ffff);  // must not stick in $0
        run_inst(r_inst(1, 2, 9, 0, fn_addu), 32'h0000_0300);
        compare("rs_value", rs_value, vals[1]);
        compare("rt_value", rt_value, vals[2]);
        run_inst(r_inst(3, 4, 9, 0, fn_addu), 32'h0000_0300);
        compare("rs_value", rs_value, vals[3]);
        compare("rt_value", rt_value, vals[4]);
        run_inst(r_inst(0, 4, 9, 0, fn_addu), 32'h0000_0300);
        compare("rs_value", rs_value, 0);
        compare("rt_value", rt_value, vals[4]);
        // write lands while the reader is in decode
        fwd = $random(seed);
        offer_inst(r_inst(5, 0, 9, 0, fn_addu), 32'h0000_0300);
        take_inst(32'h0000_0304);
        wb_we   <= 1'b1;
        wb_addr <= 5;
        wb_data <= fwd;
        @(negedge clk);
        compare("rs_value", rs_value, fwd);
        compare("rt_value", rt_value, 0);
        @(posedge clk);
        wb_we <= 1'b0;
        run_inst(r_inst(5, 0, 9, 0, fn_addu), 32'h0000_0300);
        compare("rs_value", rs_value, fwd);
    endtask

    task automatic bypass_priority();
        offer_inst(r_inst(6, 6, 9, 0, fn_addu), 32'h0000_0400);
        take_inst(32'h0000_0404);
        es_allowin <= 1'b0;  // hold the instruction in decode
        es_dest    <= 6;
        es_res     <= 32'haaaa_0001;
        ms_dest    <= 6;
        ms_res     <= 32'hbbbb_0002;
        wb_we      <= 1'b1;
        wb_addr    <= 6;
        wb_data    <= 32'hcccc_0003;
        @(negedge clk);
        compare("ds_to_es_valid", ds_to_es_valid, 1);
        compare("rs_value", rs_value, 32'haaaa_0001);
        compare("rt_value", rt_value, 32'haaaa_0001);
        @(posedge clk);
        es_dest <= 0;
        @(negedge clk);
        compare("rs_value", rs_value, 32'hbbbb_0002);
        @(posedge clk);
        ms_dest <= 0;
        wb_data <= 32'hdddd_0004;  // file still holds the older value
        @(negedge clk);
        compare("rs_value", rs_value, 32'hdddd_0004);
        @(posedge clk);
        wb_we <= 1'b0;
        @(negedge clk);
        compare("rs_value", rs_value, 32'hdddd_0004);
        @(posedge clk);
        es_allowin <= 1'b1;
    endtask

    task automatic load_use_stall();
        @(posedge clk);
        es_dest      <= 7;
        es_res_valid <= 1'b0;  // load still in execute
        es_res       <= 32'h1234_5678;
        offer_inst(r_inst(7, 0, 9, 0, fn_addu), 32'h0000_0500);
        take_inst(32'h0000_0504);
        repeat (2) begin
            @(negedge clk);
            compare("ds_to_es_valid", ds_to_es_valid, 0);
            compare("ds_allowin", ds_allowin, 0);
            @(posedge clk);
        end
        es_res_valid <= 1'b1;
        wait_issue();
        compare("rs_value", rs_value, 32'h1234_5678);
        compare("ds_allowin", ds_allowin, 1);
        @(posedge clk);
        es_dest <= 0;
    endtask

    task automatic branch_case(input word_t inst, input word_t pc, input logic taken,
                               input word_t target);
        run_inst(inst, pc);
        compare("br_valid", br_valid, 1);
        compare("br_stall", br_stall, 0);
        compare("br_taken", br_taken, taken);
        compare("br_target", br_target, target);
    endtask

    task automatic branch_resolve();
        write_reg(10, 32'd5);
        write_reg(11, 32'd5);
        write_reg(12, 32'hffff_fff0);
        write_reg(13, 32'd0);
        write_reg(14, 32'h0040_0100);
        write_reg(15, 32'd7);
        branch_case(i_inst(op_beq, 10, 11, 16'h0010), 32'h0000_1000, 1, 32'h0000_1044);
        branch_case(i_inst(op_beq, 10, 15, 16'h0010), 32'h0000_1000, 0, 32'h0000_1044);
        branch_case(i_inst(op_bne, 10, 15, 16'hfffc), 32'h0000_2000, 1, 32'h0000_1ff4);
        branch_case(i_inst(op_bne, 10, 11, 16'hfffc), 32'h0000_2000, 0, 32'h0000_1ff4);
        branch_case(i_inst(op_regimm, 13, 1, 16'h0008), 32'h0000_3000, 1, 32'h0000_3024);
        branch_case(i_inst(op_regimm, 12, 1, 16'h0008), 32'h0000_3000, 0, 32'h0000_3024);
        branch_case(i_inst(op_bgtz, 15, 0, 16'h0008), 32'h0000_3000, 1, 32'h0000_3024);
        branch_case(i_inst(op_bgtz, 13, 0, 16'h0008), 32'h0000_3000, 0, 32'h0000_3024);
        branch_case(i_inst(op_blez, 12, 0, 16'h0008), 32'h0000_3000, 1, 32'h0000_3024);
        branch_case(i_inst(op_blez, 15, 0, 16'h0008), 32'h0000_3000, 0, 32'h0000_3024);
        branch_case(i_inst(op_regimm, 12, 0, 16'h0008), 32'h0000_3000, 1, 32'h0000_3024);
        branch_case(i_inst(op_regimm, 13, 0, 16'h0008), 32'h0000_3000, 0, 32'h0000_3024);
        branch_case(j_inst(op_j, 26'h010_0040), 32'h9000_0000, 1, 32'h9040_0100);
        branch_case(j_inst(op_jal, 26'h010_0040), 32'h9000_0000, 1, 32'h9040_0100);
        branch_case(r_inst(14, 0, 0, 0, fn_jr), 32'h0000_5000, 1, 32'h0040_0100);
        branch_case(r_inst(14, 0, 31, 0, fn_jalr), 32'h0000_5000, 1, 32'h0040_0100);
        // compare operand not ready in execute
        @(posedge clk);
        es_dest      <= 10;
        es_res_valid <= 1'b0;
        es_res       <= 32'd5;
        offer_inst(i_inst(op_beq, 10, 11, 16'h0010), 32'h0000_1000);
        take_inst(32'h0000_1004);
        @(negedge clk);
        compare("br_stall", br_stall, 1);
        compare("br_valid", br_valid, 0);
        @(posedge clk);
        es_res_valid <= 1'b1;
        wait_issue();
        compare("br_stall", br_stall, 0);
        compare("br_taken", br_taken, 1);
        compare("br_target", br_target, 32'h0000_1044);
        @(posedge clk);
        es_dest <= 0;
    endtask

    task automatic backpressure_flush();
        offer_inst(r_inst(1, 2, 3, 0, fn_subu), 32'h0000_4000);
        take_inst(32'h0000_4004);
        es_allowin <= 1'b0;
        @(negedge clk);
        compare("ds_to_es_valid", ds_to_es_valid, 1);
        compare("ds_allowin", ds_allowin, 0);
        @(posedge clk);
        fs_valid <= 1'b1;  // next instruction waits in fetch
        fs_inst  <= r_inst(1, 2, 3, 0, fn_or);
        repeat (2) begin
            @(negedge clk);
            compare("ds_to_es_valid", ds_to_es_valid, 1);
            compare("ds_pc", ds_pc, 32'h0000_4000);
            compare("alu_op", alu_op, 32'd1 << alu_sub);
            compare("ds_allowin", ds_allowin, 0);
            @(posedge clk);
        end
        flush <= 1'b1;
        @(posedge clk);
        flush      <= 1'b0;
        fs_valid   <= 1'b0;
        es_allowin <= 1'b1;
        @(negedge clk);
        compare("ds_to_es_valid", ds_to_es_valid, 0);
        compare("ds_allowin", ds_allowin, 1);
    endtask

    initial begin
        seed         = 66817;
        err_count    = 0;
        cycle_count  = 0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        fs_valid     = 1'b0;
        fs_inst      = '0;
        fs_pc        = '0;
        es_allowin   = 1'b1;
        es_res_valid = 1'b1;
        es_dest      = '0;
        es_res       = '0;
        ms_res_valid = 1'b1;
        ms_dest      = '0;
        ms_res       = '0;
        wb_we        = 1'b0;
        wb_addr      = '0;
        wb_data      = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare("ds_to_es_valid", ds_to_es_valid, 0);
        compare("br_valid", br_valid, 0);
        compare("br_taken", br_taken, 0);
        compare("ds_allowin", ds_allowin, 1);
        decode_fields();
        regfile_forward();
        bypass_priority();
        load_use_stall();
        branch_resolve();
        backpressure_flush();
        @(posedge clk);
        if (err_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* sim.f */
hw/decode_pkg.sv
hw/bypass_if.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/branch_unit.sv
hw/decode_stage.sv
tests/tb_decode_stage.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench, verdict from the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_decode_stage -f sim.f -o sim_decode \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_decode > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
